// File: dv/boot_config_stimulus.txt
// Columns: io1 io2 board_id is_v30 kind match led
// led is index then red, green, blue; match holds one bit per kind with none in bit 0
3FFFFFFFF FFFFFFFFFF 5 0 0 1 3102040
27FFFFFFE 807FFFF755 2 1 1 2 0112233
2FF57EDFF FBCFBF7BFF 9 1 3 8 2A4105C
3FFFFFFFE FFFFFFFFFF 3 0 2 4 5445566
3FFFFEFFE FFFFFFFFFF 0 1 0 0 1778899
2FF57EDFF FBCFBF7BFF C 0 3 8 6FF0081

// File: filelist.f
design/bcfg_pkg.sv
design/io_snapshot.sv
design/signature_match.sv
design/board_classifier.sv
design/led_chain_driver.sv
design/bcfg_apb_regs.sv
design/boot_config_top.sv
dv/bcfg_clkgen.sv
dv/tb_boot_config.sv

// File: run_sim.sh
#!/bin/sh
# Build the boot configuration testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_boot_config \
    -f filelist.f -o tb_boot_config > sim.log 2>&1 \
    && ./obj_dir/tb_boot_config >> sim.log 2>&1 \
    || echo "TEST RESULT: FAIL" >> sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
exit 0

// File: dv/tb_boot_config.sv
// Boot configuration testbench that drives pin patterns and APB and checks status, registers and LED chain
`timescale 1ns/10ps

module tb_boot_config import bcfg_pkg::*; ();

    localparam int settle_cycles  = 16;
    localparam int num_leds       = 7;
    localparam int led_bit_cycles = 12;
    // Seven hex columns per stimulus line
    localparam int fields       = 7;
    localparam int max_lines    = 16;
    localparam int max_polls    = 8;
    // One chain is every LED frame plus the latch gap
    localparam int chain_cycles = (num_leds * 24 + 4) * led_bit_cycles;
    localparam int line_budget  = settle_cycles + 8 * chain_cycles;

    logic                 sysclk;
    logic                 rst_n;
    logic [3:0]           board_id;
    logic                 is_v30;
    logic [io1_width-1:0] io1;
    logic [io2_width-1:0] io2;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [7:0]           paddr;
    logic [31:0]          pwdata;
    logic [31:0]          prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 led_data;
    logic                 led_oe;

    logic [39:0]          stim_mem [0:max_lines*fields-1];
    logic [sig_width-1:0] free_mask;
    int                   num_lines = 0;
    int                   cyc_cnt = 0;
    int                   sample_cycle;
    integer               seed;

    bcfg_clkgen #(.reset_cycles(8)) clkgen_i (.sysclk(sysclk), .rst_n(rst_n));

    boot_config_top #(
        .settle_cycles(settle_cycles),
        .num_leds(num_leds),
        .led_bit_cycles(led_bit_cycles)
    ) dut_i (
        .sysclk(sysclk), .rst_n(rst_n), .board_id(board_id), .is_v30(is_v30),
        .io1(io1), .io2(io2), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .led_data(led_data), .led_oe(led_oe)
    );

    // Reference count of clock cycles for the timestamp check
    always @(posedge sysclk) cyc_cnt <= cyc_cnt + 1;

    // ------------------------------
    // Error reporting
    // ------------------------------
    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic stop_on_error(input string what);
        $display("error: %s", what);
        abort_run();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("mismatch %s expected 0x%h got 0x%h", name, exp, got);
        abort_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else report_mismatch(name, exp, got);
    endtask

    // ------------------------------
    // APB master
    // ------------------------------
    // Setup phase, then access phase sampled at the falling edge
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge sysclk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge sysclk);
        #1;
        penable = 1'b1;
        @(negedge sysclk);
        rdata        = prdata;
        err          = pslverr;
        sample_cycle = cyc_cnt;
        assert (pready) else stop_on_error("pready low in the APB access phase");
        @(posedge sysclk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'd0, data, err);
        check_value("pslverr", 32'd0, 32'(err));
    endtask

    // ------------------------------
    // Stimulus and LED line decode
    // ------------------------------
    task automatic load_stimulus();
        // All ones marks an unused entry since no io1 value is that wide
        for (int i = 0; i < max_lines * fields; i++)
            stim_mem[i] = '1;
        $readmemh("dv/boot_config_stimulus.txt", stim_mem);
        num_lines = 0;
        while (num_lines < max_lines && stim_mem[fields*num_lines] != '1)
            num_lines++;
    endtask

    // Pins that no signature except NONE looks at
    function automatic logic [sig_width-1:0] free_pins();
        logic [sig_width-1:0] used;
        used = '0;
        for (int k = 1; k < num_boards; k++)
            used = used | sig_zero_mask[k] | sig_one_mask[k];
        return ~used;
    endfunction

    // Latch gap is far longer than any low time inside a chain
    task automatic wait_chain_start();
        int low_run;
        low_run = 0;
        while (low_run < 2 * led_bit_cycles) begin
            @(negedge sysclk);
            if (led_data)
                low_run = 0;
            else
                low_run++;
        end
    endtask

    // High time decides the bit and bits arrive MSB first
    task automatic read_frame(output logic [23:0] frame);
        int high_cnt;
        frame = '0;
        for (int b = 0; b < 24; b++) begin
            while (!led_data) @(negedge sysclk);
            high_cnt = 0;
            while (led_data) begin
                high_cnt++;
                @(negedge sysclk);
            end
            assert (high_cnt == led_bit_cycles / 3 || high_cnt == 2 * led_bit_cycles / 3)
                else stop_on_error($sformatf("LED bit high for %0d cycles", high_cnt));
            frame = {frame[22:0], high_cnt > led_bit_cycles / 2};
        end
    endtask

    // ------------------------------
    // Test sequences
    // ------------------------------
    task automatic check_fixed_regs();
        logic [31:0] rd;
        logic [31:0] ts1;
        logic [31:0] ts2;
        logic        err;
        int          c1;
        int          c2;
        read_reg(reg_version, rd);
        check_value("prdata version", 32'h4243_4647, rd);
        read_reg(reg_timestamp, ts1);
        c1 = sample_cycle;
        repeat (37) @(posedge sysclk);
        read_reg(reg_timestamp, ts2);
        c2 = sample_cycle;
        check_value("timestamp delta", 32'(c2 - c1), ts2 - ts1);
        // Unmapped offset
        apb_access(1'b0, 8'h18, 32'd0, rd, err);
        check_value("pslverr unmapped read", 32'd1, 32'(err));
        check_value("prdata unmapped read", 32'd0, rd);
        // Status is read only
        apb_access(1'b1, reg_status, 32'hFFFF_FFFF, rd, err);
        check_value("pslverr status write", 32'd1, 32'(err));
    endtask

    task automatic run_pattern(input int n);
        logic [sig_width-1:0] pins;
        logic [95:0]          rnd96;
        logic [3:0]           bid;
        logic                 v30;
        logic [1:0]           kind;
        logic [3:0]           mvec;
        logic [27:0]          led;
        logic [31:0]          rd;
        logic [23:0]          frame;
        logic [23:0]          exp_frame;
        logic                 err;
        int                   polls;
        pins  = {stim_mem[fields*n][io1_width-1:0], stim_mem[fields*n+1][io2_width-1:0]};
        bid   = stim_mem[fields*n+2][3:0];
        v30   = stim_mem[fields*n+3][0];
        kind  = stim_mem[fields*n+4][1:0];
        mvec  = stim_mem[fields*n+5][3:0];
        led   = stim_mem[fields*n+6][27:0];
        // NONE tests every pin, so its patterns go out as written
        if (!mvec[0]) begin
            rnd96 = {$random(seed), $random(seed), $random(seed)};
            pins  = (pins & ~free_mask) | (rnd96[sig_width-1:0] & free_mask);
        end
        @(posedge sysclk);
        #1;
        io1      = pins[sig_width-1:io2_width];
        io2      = pins[io2_width-1:0];
        board_id = bid;
        is_v30   = v30;
        // Synchronizer, settle window, matcher and classifier
        repeat (settle_cycles + 6) @(posedge sysclk);
        read_reg(reg_status, rd);
        polls = 1;
        while (!rd[16] && polls < max_polls) begin
            read_reg(reg_status, rd);
            polls++;
        end
        assert (rd[16]) else stop_on_error("status valid never set after the pins settled");
        check_value("status.kind", 32'(kind), 32'(rd[19:18]));
        check_value("status.match", 32'(mvec), 32'(rd[23:20]));
        check_value("status.board_id", 32'(bid), 32'(rd[27:24]));
        check_value("status.is_v30", 32'(v30), 32'(rd[17]));
        check_value("status spare bits", 32'd0, rd & 32'hF000_FFFF);
        read_reg(reg_digin, rd);
        check_value("digin", {io1[33:10], io2[7:0]}, rd);
        read_reg(reg_tempsns, rd);
        check_value("tempsns", io2[39:8], rd);
        apb_access(1'b1, reg_led, {4'd0, led}, rd, err);
        check_value("pslverr led write", 32'd0, 32'(err));
        if (kind == board_drac) begin
            @(negedge sysclk);
            assert (led_oe) else stop_on_error("led_oe low with a DRAC board detected");
            wait_chain_start();
            for (int l = 0; l < num_leds; l++) begin
                read_frame(frame);
                // Green, red, blue on the wire
                exp_frame = (4'(l) == led[27:24]) ? {led[15:8], led[23:16], led[7:0]} : 24'd0;
                check_value("led_data frame", 32'(exp_frame), 32'(frame));
            end
        end else begin
            repeat (2 * led_bit_cycles) begin
                @(negedge sysclk);
                assert (!led_oe && !led_data)
                    else stop_on_error("LED line active without a DRAC board");
            end
        end
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------
    initial begin
        logic [31:0] rd;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = 8'd0;
        pwdata    = 32'd0;
        board_id  = 4'd0;
        is_v30    = 1'b0;
        // Idle connector reads all ones
        io1       = '1;
        io2       = '1;
        seed      = 32'hf265_ae4a;
        free_mask = free_pins();
        load_stimulus();
        if (num_lines == 0)
            stop_on_error("stimulus file holds no pattern lines");
        wait (rst_n);
        @(negedge sysclk);
        check_value("led_oe after reset", 32'd0, 32'(led_oe));
        check_value("led_data after reset", 32'd0, 32'(led_data));
        check_value("pready after reset", 32'd0, 32'(pready));
        check_value("pslverr after reset", 32'd0, 32'(pslverr));
        read_reg(reg_status, rd);
        check_value("status.valid after reset", 32'd0, 32'(rd[16]));
        check_fixed_regs();
        for (int n = 0; n < num_lines; n++)
            run_pattern(n);
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        wait (num_lines > 0);
        repeat (num_lines * line_budget) @(posedge sysclk);
        stop_on_error("watchdog expired before the tests finished");
    end

endmodule

// File: dv/bcfg_clkgen.sv
// Testbench clock and reset source: 10 ns clock, active-low reset held for a fixed count of cycles
`timescale 1ns/10ps

module bcfg_clkgen #(
    parameter int reset_cycles = 8
) (
    output logic sysclk,
    output logic rst_n
);

    // 100 MHz
    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;
    end

    // Release just after an edge, same as the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge sysclk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// File: design/boot_config_top.sv
// Boot configuration top: pin snapshot, board matchers, classifier, APB and LED chain
`timescale 1ns/10ps

module boot_config_top import bcfg_pkg::*; #(
    parameter int settle_cycles  = 16,
    parameter int num_leds       = 7,
    parameter int led_bit_cycles = 12
) (
    input  logic                 sysclk,
    input  logic                 rst_n,
    // Rotary switch and FPGA revision
    input  logic [3:0]           board_id,
    input  logic                 is_v30,
    // Connector pins, pulled up
    input  logic [io1_width-1:0] io1,
    input  logic [io2_width-1:0] io2,
    // APB slave
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [7:0]           paddr,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    // Front-panel LED line and its pad enable
    output logic                 led_data,
    output logic                 led_oe
);

    io_snap_t              snap;
    logic                  snap_valid;
    logic [num_boards-1:0] match;
    board_status_t         status;
    led_cmd_t              led_cmd;
    logic                  led_cmd_valid;
    logic                  drac_en;

    io_snapshot #(.settle_cycles(settle_cycles)) u_snapshot (
        .sysclk(sysclk), .rst_n(rst_n), .io1(io1), .io2(io2),
        .snap(snap), .snap_valid(snap_valid)
    );

    // One matcher per board kind
    for (genvar i = 0; i < num_boards; i++) begin : g_match
        signature_match #(.kind(board_kind_e'(i))) u_match (
            .sysclk(sysclk), .rst_n(rst_n), .snap(snap),
            .snap_valid(snap_valid), .match(match[i])
        );
    end

    board_classifier u_classifier (
        .sysclk(sysclk), .rst_n(rst_n), .match(match), .snap_valid(snap_valid),
        .board_id(board_id), .is_v30(is_v30), .status(status)
    );

    bcfg_apb_regs u_regs (
        .sysclk(sysclk), .rst_n(rst_n), .psel(psel), .penable(penable),
        .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr), .snap(snap), .status(status),
        .led_cmd(led_cmd), .led_cmd_valid(led_cmd_valid)
    );

    // LED pin only exists on the DRAC board
    assign drac_en = status.valid && (status.kind == board_drac);

    led_chain_driver #(
        .num_leds(num_leds),
        .led_bit_cycles(led_bit_cycles)
    ) u_led (
        .sysclk(sysclk), .rst_n(rst_n), .cmd(led_cmd), .cmd_valid(led_cmd_valid),
        .enable(drac_en), .led_data(led_data), .led_oe(led_oe)
    );

endmodule

// File: design/bcfg_apb_regs.sv
// APB register slave: board status, pin words, version, timestamp and LED command
`timescale 1ns/10ps

module bcfg_apb_regs import bcfg_pkg::*; (
    input  logic          sysclk,
    input  logic          rst_n,
    input  logic          psel,
    input  logic          penable,
    input  logic          pwrite,
    input  logic [7:0]    paddr,
    input  logic [31:0]   pwdata,
    output logic [31:0]   prdata,
    output logic          pready,
    output logic          pslverr,
    input  io_snap_t      snap,
    input  board_status_t status,
    output led_cmd_t      led_cmd,
    output logic          led_cmd_valid
);

    localparam int cmd_bits = $bits(led_cmd_t);

    logic        access;
    logic        addr_hit;
    logic        led_wr;
    logic [31:0] timestamp;
    logic [31:0] status_word;
    logic [31:0] rd_word;

    // No wait states, every access phase completes
    assign access = psel && penable;
    assign pready = access;

    // Status layout
    // 27:24 board id, 23:20 match, 19:18 kind, 17 v3.0, 16 valid
    assign status_word = {4'd0, status.board_id, status.match, status.kind,
                          status.is_v30, status.valid, 16'd0};

    // ------------------------------
    // Read decode
    // ------------------------------
    always_comb begin
        addr_hit = 1'b1;
        rd_word  = 32'd0;
        case (paddr)
            reg_status:    rd_word = status_word;
            // Spare pins of the snapshot
            reg_digin:     rd_word = {snap.io1[33:10], snap.io2[7:0]};
            reg_tempsns:   rd_word = snap.io2[39:8];
            reg_version:   rd_word = version_word;
            reg_timestamp: rd_word = timestamp;
            reg_led:       rd_word = {{(32 - cmd_bits){1'b0}}, led_cmd};
            default:       addr_hit = 1'b0;
        endcase
    end

    assign prdata  = (access && !pwrite) ? rd_word : 32'd0;
    // Unmapped offset, or a write anywhere but the LED register
    assign pslverr = access && (!addr_hit || (pwrite && paddr != reg_led));
    assign led_wr  = access && pwrite && (paddr == reg_led);

    // ------------------------------
    // Timestamp and LED command
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            timestamp     <= 32'd0;
            led_cmd       <= '0;
            led_cmd_valid <= 1'b0;
        end else begin
            // Free-running, wraps
            timestamp     <= timestamp + 1'b1;
            led_cmd_valid <= led_wr;
            if (led_wr)
                led_cmd <= led_cmd_t'(pwdata[cmd_bits-1:0]);
        end
    end

    // Access phase only ever follows a select
    assert property (@(posedge sysclk) disable iff (!rst_n) penable |-> psel);

endmodule

// File: design/led_chain_driver.sv
// Front-panel LED driver: serializes 24-bit WS2811 frames along the LED chain
`timescale 1ns/10ps

module led_chain_driver import bcfg_pkg::*; #(
    parameter int num_leds       = 7,
    parameter int led_bit_cycles = 12
) (
    input  logic     sysclk,
    input  logic     rst_n,
    input  led_cmd_t cmd,
    input  logic     cmd_valid,
    input  logic     enable,
    output logic     led_data,
    output logic     led_oe
);

    localparam int phase_w    = $clog2(led_bit_cycles);
    // High time for a 0 and for a 1
    localparam int t0_cycles  = led_bit_cycles / 3;
    localparam int t1_cycles  = (2 * led_bit_cycles) / 3;
    localparam int latch_bits = 4;

    typedef enum logic [1:0] {st_idle, st_send, st_latch} state_e;

    state_e             state;
    logic [phase_w-1:0] phase_cnt;
    logic [4:0]         bit_cnt;
    logic [3:0]         led_cnt;
    logic [23:0]        frame_q;
    led_cmd_t           pend_cmd;
    led_cmd_t           act_cmd;
    logic               bit_end;
    logic               frame_end;
    logic               chain_end;
    logic               latch_end;
    logic               start_chain;
    logic [phase_w-1:0] high_time;

    // Colour only for the addressed LED, green first
    function automatic logic [23:0] frame_for(led_cmd_t c, logic [3:0] idx);
        return (idx == c.index) ? {c.green, c.red, c.blue} : 24'd0;
    endfunction

    assign bit_end   = (phase_cnt == phase_w'(led_bit_cycles - 1));
    assign frame_end = bit_end && (bit_cnt == 5'd23);
    assign chain_end = frame_end && (led_cnt == 4'(num_leds - 1));
    assign latch_end = bit_end && (bit_cnt == 5'(latch_bits - 1));
    // Back-to-back chains while enabled
    assign start_chain = enable && (state == st_idle || (state == st_latch && latch_end));
    assign high_time   = frame_q[23] ? phase_w'(t1_cycles) : phase_w'(t0_cycles);

    // ------------------------------
    // Serializer control
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state     <= st_idle;
            phase_cnt <= '0;
            bit_cnt   <= '0;
            led_cnt   <= '0;
            pend_cmd  <= '0;
            led_data  <= 1'b0;
            led_oe    <= 1'b0;
        end else begin
            led_oe   <= enable;
            led_data <= enable && (state == st_send) && (phase_cnt < high_time);
            // Latest command waits for the next chain
            if (cmd_valid)
                pend_cmd <= cmd;
            if (!enable) begin
                state <= st_idle;
            end else if (start_chain) begin
                state     <= st_send;
                phase_cnt <= '0;
                bit_cnt   <= '0;
                led_cnt   <= '0;
            end else if (bit_end) begin
                phase_cnt <= '0;
                if (state == st_send && frame_end) begin
                    bit_cnt <= '0;
                    if (chain_end) begin
                        state   <= st_latch;
                        led_cnt <= '0;
                    end else begin
                        led_cnt <= led_cnt + 1'b1;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                phase_cnt <= phase_cnt + 1'b1;
            end
        end
    end

    // Frame shifter, MSB out first
    always_ff @(posedge sysclk) begin
        if (start_chain) begin
            act_cmd <= pend_cmd;
            frame_q <= frame_for(pend_cmd, 4'd0);
        end else if (state == st_send && bit_end) begin
            if (frame_end)
                frame_q <= frame_for(act_cmd, led_cnt + 1'b1);
            else
                frame_q <= {frame_q[22:0], 1'b0};
        end
    end

    // Register writes must address an LED in the chain
    assert property (@(posedge sysclk) disable iff (!rst_n)
        cmd_valid |-> (cmd.index < 4'(num_leds)));

endmodule

// File: design/board_classifier.sv
// Board classifier: merges the matcher flags into one registered status word
`timescale 1ns/10ps

module board_classifier import bcfg_pkg::*; (
    input  logic                  sysclk,
    input  logic                  rst_n,
    input  logic [num_boards-1:0] match,
    input  logic                  snap_valid,
    input  logic [3:0]            board_id,
    input  logic                  is_v30,
    output board_status_t         status
);

    board_kind_e kind_sel;
    // snap_valid delayed to line up with the matcher outputs
    logic        valid_d;

    // Lowest matching code wins, none when nothing hits
    always_comb begin
        kind_sel = board_none;
        for (int k = num_boards - 1; k >= 0; k--) begin
            if (match[k])
                kind_sel = board_kind_e'(k);
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            valid_d <= 1'b0;
            status  <= '0;
        end else begin
            valid_d         <= snap_valid;
            status.board_id <= board_id;
            status.is_v30   <= is_v30;
            status.match    <= match;
            status.kind     <= kind_sel;
            status.valid    <= valid_d;
        end
    end

    // Board signatures are mutually exclusive
    assert property (@(posedge sysclk) disable iff (!rst_n) snap_valid |-> $onehot0(match));

endmodule

// File: design/signature_match.sv
// Board signature matcher: tests the snapshot against one board's pin masks
`timescale 1ns/10ps

module signature_match import bcfg_pkg::*; #(
    parameter board_kind_e kind = board_none
) (
    input  logic     sysclk,
    input  logic     rst_n,
    input  io_snap_t snap,
    input  logic     snap_valid,
    output logic     match
);

    localparam logic [sig_width-1:0] zero_mask = sig_zero_mask[kind];
    localparam logic [sig_width-1:0] one_mask  = sig_one_mask[kind];

    logic [sig_width-1:0] pins;
    logic                 zeros_ok;
    logic                 ones_ok;

    // io1 sits above io2, same as the mask layout
    assign pins = snap;

    // Masked pins must read 0
    assign zeros_ok = ((pins & zero_mask) == '0);
    // Masked pins must read 1
    assign ones_ok  = ((pins & one_mask) == one_mask);

    // One cycle from snapshot to flag
    always_ff @(posedge sysclk) begin
        if (!rst_n)
            match <= 1'b0;
        else
            match <= snap_valid && zeros_ok && ones_ok;
    end

endmodule

// File: design/io_snapshot.sv
// Pin sampler: synchronizes both banks and latches them once they have settled
`timescale 1ns/10ps

module io_snapshot import bcfg_pkg::*; #(
    parameter int settle_cycles = 16
) (
    input  logic                 sysclk,
    input  logic                 rst_n,
    input  logic [io1_width-1:0] io1,
    input  logic [io2_width-1:0] io2,
    output io_snap_t             snap,
    output logic                 snap_valid
);

    localparam int cnt_w = $clog2(settle_cycles + 1);

    io_snap_t        meta_q;
    io_snap_t        sync_q;
    io_snap_t        last_q;
    logic [cnt_w-1:0] settle_cnt;
    logic            changed;
    logic            settled;

    // Two-stage synchronizer on every pin
    always_ff @(posedge sysclk) begin
        meta_q <= '{io1: io1, io2: io2};
        sync_q <= meta_q;
    end

    assign changed = (sync_q != last_q);
    // Last cycle of the settle window
    assign settled = !changed && (settle_cnt == cnt_w'(settle_cycles - 1));

    // Stability counter, parks at settle_cycles
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            // Pull-ups make all ones the idle value
            last_q     <= '1;
            settle_cnt <= '0;
            snap_valid <= 1'b0;
        end else if (changed) begin
            last_q     <= sync_q;
            settle_cnt <= '0;
        end else if (settle_cnt != cnt_w'(settle_cycles)) begin
            settle_cnt <= settle_cnt + 1'b1;
            if (settled)
                snap_valid <= 1'b1;
        end
    end

    always_ff @(posedge sysclk) begin
        if (settled)
            snap <= last_q;
    end

    // Once a snapshot exists it stays valid
    assert property (@(posedge sysclk) disable iff (!rst_n) snap_valid |=> snap_valid);

endmodule

// File: design/bcfg_pkg.sv
// Board configuration check: shared widths, register map, signatures and bus types
package bcfg_pkg;

    // ------------------------------
    // Pin banks
    // ------------------------------
    localparam int io1_width = 34;
    localparam int io2_width = 40;
    // Joined word, io1 in the upper bits
    localparam int sig_width = io1_width + io2_width;
    localparam int num_boards = 4;

    typedef enum logic [1:0] {
        board_none = 2'd0,
        board_qla  = 2'd1,
        board_dqla = 2'd2,
        board_drac = 2'd3
    } board_kind_e;

    // ------------------------------
    // Board signatures
    // ------------------------------
    // Zero-mask: pins that must read 0
    // Index order none, qla, dqla, drac
    localparam logic [sig_width-1:0] sig_zero_mask [0:num_boards-1] = '{
        {34'h0_0000_0000, 40'h00_0000_0000},
        {34'h1_8000_0001, 40'h7F_8000_08AA},
        {34'h0_0000_0001, 40'h00_0000_0000},
        {34'h1_00A8_1200, 40'h04_3040_8400}
    };

    // One-mask: pins that must read 1
    // QLA has none, its zero pins are enough to tell it apart
    localparam logic [sig_width-1:0] sig_one_mask [0:num_boards-1] = '{
        {34'h3_FFFF_FFFF, 40'hFF_FFFF_FFFF},
        {34'h0_0000_0000, 40'h00_0000_0000},
        {34'h0_8000_1000, 40'h00_0000_0000},
        {34'h0_0000_0000, 40'h11_8000_000A}
    };

    // ------------------------------
    // Register map
    // ------------------------------
    localparam logic [7:0] reg_status    = 8'h00;
    localparam logic [7:0] reg_digin     = 8'h04;
    localparam logic [7:0] reg_tempsns   = 8'h08;
    localparam logic [7:0] reg_version   = 8'h0C;
    localparam logic [7:0] reg_timestamp = 8'h10;
    localparam logic [7:0] reg_led       = 8'h14;

    // ASCII "BCFG"
    localparam logic [31:0] version_word = 32'h42434647;

    typedef struct packed {
        logic [io1_width-1:0] io1;
        logic [io2_width-1:0] io2;
    } io_snap_t;

    typedef struct packed {
        logic [3:0]  board_id;
        logic        is_v30;
        logic [3:0]  match;
        board_kind_e kind;
        logic        valid;
    } board_status_t;

    typedef struct packed {
        logic [3:0] index;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } led_cmd_t;

endpackage
